//--- src/memPkg.sv
// even parity per byte, the address field is wider than any memory built from it
`default_nettype none

package memPkg;

    localparam int DATA_WIDTH     = 32;
    localparam int BYTE_COUNT     = 4;
    localparam int MAX_ADDR_WIDTH = 16;

    // stored word carries one parity bit per byte above the data
    localparam int STORED_WIDTH   = DATA_WIDTH + BYTE_COUNT;

    typedef logic [DATA_WIDTH-1:0]     dataT;
    typedef logic [BYTE_COUNT-1:0]     byteMaskT;
    typedef logic [MAX_ADDR_WIDTH-1:0] addrT;
    typedef logic [STORED_WIDTH-1:0]   storedWordT;

    // request as seen on the external port
    typedef struct packed {
        logic     write;
        logic     poison;
        byteMaskT byteMask;
        addrT     addr;
        dataT     data;
    } memRequestT;

    // request after parity generation, word[35:32] holds the parity bits
    typedef struct packed {
        logic       write;
        byteMaskT   byteMask;
        addrT       addr;
        storedWordT word;
    } storedRequestT;

    // read response, one error flag per byte
    typedef struct packed {
        dataT     data;
        byteMaskT parityErr;
    } memResponseT;

endpackage

`default_nettype wire

//--- src/requestIssuer.sv
// FIFO_DEPTH must match the downstream FIFO depth, inReady only means a credit is left
`timescale 1ns/1ps
`default_nettype none

module requestIssuer #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inValid,
    output logic                  inReady,
    input  memPkg::memRequestT    inReq,
    output logic                  pushValid,
    output memPkg::storedRequestT pushItem,
    input  logic                  creditReturn
);
    import memPkg::*;

    localparam int CREDIT_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [CREDIT_WIDTH-1:0] creditCount;
    logic                    accept;
    byteMaskT                parityBits;
    logic                    invertParity;

    assign inReady = (creditCount != '0);
    assign accept  = inValid && inReady;

    // poisoned writes store inverted parity so reads flag those bytes
    assign invertParity = inReq.write && inReq.poison;

    always_comb begin
        for (int i = 0; i < BYTE_COUNT; i++) begin
            parityBits[i] = (^inReq.data[i*8 +: 8]) ^ invertParity;
        end
    end

    // one credit per accepted request, returned when the memory pops it
    always_ff @(posedge clk) begin
        if (reset) begin
            creditCount <= CREDIT_WIDTH'(FIFO_DEPTH);
        end else begin
            case ({accept, creditReturn})
                2'b10:   creditCount <= creditCount - 1'b1;
                2'b01:   creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pushValid <= 1'b0;
        end else begin
            pushValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pushItem.write    <= inReq.write;
            pushItem.byteMask <= inReq.byteMask;
            pushItem.addr     <= inReq.addr;
            pushItem.word     <= {parityBits, inReq.data[DATA_WIDTH-1:0]};
        end
    end

endmodule

`default_nettype wire

//--- src/creditFifo.sv
// no full flag, the pusher must hold a credit for every push
`timescale 1ns/1ps
`default_nettype none

module creditFifo #(
    parameter int  DEPTH = 4,
    parameter type itemT = logic [7:0]
) (
    input  logic clk,
    input  logic reset,
    input  logic pushValid,
    input  itemT pushItem,
    output logic popValid,
    output itemT popItem,
    input  logic popTake,
    output logic creditReturn
);

    localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    itemT                   buffer [DEPTH];
    logic [PTR_WIDTH-1:0]   wrPtr;
    logic [PTR_WIDTH-1:0]   rdPtr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   doPop;

    // wrap explicitly so depths other than powers of two work
    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        logic [PTR_WIDTH-1:0] result;
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign popValid     = (count != '0);
    assign popItem      = buffer[rdPtr];
    assign doPop        = popValid && popTake;
    // a credit goes back in the same cycle the entry leaves
    assign creditReturn = doPop;

    always_ff @(posedge clk) begin
        if (pushValid) begin
            buffer[wrPtr] <= pushItem;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushValid, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/parityMemory.sv
// storage has no reset and no preload, reads of unwritten words return undefined data
`timescale 1ns/1ps
`default_nettype none

module parityMemory #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  popValid,
    input  memPkg::storedRequestT popItem,
    output logic                  popTake,
    input  logic                  rspStall,
    output logic                  rspValid,
    output memPkg::memResponseT   rsp
);
    import memPkg::*;

    localparam int WORD_COUNT = 1 << ADDR_WIDTH;
    // each byte sits beside its parity bit in a 9-bit lane
    localparam int LANE_WIDTH = 9;

    logic [STORED_WIDTH-1:0] storage [WORD_COUNT];
    logic [ADDR_WIDTH-1:0]   addr;
    logic [STORED_WIDTH-1:0] writeLanes;
    logic [STORED_WIDTH-1:0] readLanes;
    logic                    takeRead;

    // nothing leaves the FIFO while the response side stalls
    assign popTake  = popValid && !rspStall;
    assign takeRead = popTake && !popItem.write;
    assign addr     = popItem.addr[ADDR_WIDTH-1:0];

    // incoming word has parity in the top nibble, storage interleaves it
    always_comb begin
        for (int i = 0; i < BYTE_COUNT; i++) begin
            writeLanes[i*LANE_WIDTH +: LANE_WIDTH] =
                {popItem.word[DATA_WIDTH + i], popItem.word[i*8 +: 8]};
        end
    end

    always_ff @(posedge clk) begin
        if (popTake && popItem.write) begin
            for (int i = 0; i < BYTE_COUNT; i++) begin
                if (popItem.byteMask[i]) begin
                    storage[addr][i*LANE_WIDTH +: LANE_WIDTH] <=
                        writeLanes[i*LANE_WIDTH +: LANE_WIDTH];
                end
            end
        end
    end

    // response register, holds the last word read
    always_ff @(posedge clk) begin
        if (takeRead) begin
            readLanes <= storage[addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= takeRead;
        end
    end

    // a lane with even parity XORs to zero, anything else is an error
    always_comb begin
        for (int i = 0; i < BYTE_COUNT; i++) begin
            rsp.data[i*8 +: 8] = readLanes[i*LANE_WIDTH +: 8];
            rsp.parityErr[i]   = ^readLanes[i*LANE_WIDTH +: LANE_WIDTH];
        end
    end

endmodule

`default_nettype wire

//--- src/memSubsystem.sv
// ADDR_WIDTH at most 16, writes give no response, rspStall only holds back new takes
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
    parameter int ADDR_WIDTH = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                inValid,
    output logic                inReady,
    input  memPkg::memRequestT  inReq,
    input  logic                rspStall,
    output logic                rspValid,
    output memPkg::memResponseT rsp
);
    import memPkg::*;

    logic          pushValid;
    storedRequestT pushItem;
    logic          popValid;
    storedRequestT popItem;
    logic          popTake;
    logic          creditReturn;

    requestIssuer #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) issuer (
        .clk          (clk),
        .reset        (reset),
        .inValid      (inValid),
        .inReady      (inReady),
        .inReq        (inReq),
        .pushValid    (pushValid),
        .pushItem     (pushItem),
        .creditReturn (creditReturn)
    );

    creditFifo #(
        .DEPTH (FIFO_DEPTH),
        .itemT (storedRequestT)
    ) fifo (
        .clk          (clk),
        .reset        (reset),
        .pushValid    (pushValid),
        .pushItem     (pushItem),
        .popValid     (popValid),
        .popItem      (popItem),
        .popTake      (popTake),
        .creditReturn (creditReturn)
    );

    parityMemory #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) memory (
        .clk      (clk),
        .reset    (reset),
        .popValid (popValid),
        .popItem  (popItem),
        .popTake  (popTake),
        .rspStall (rspStall),
        .rspValid (rspValid),
        .rsp      (rsp)
    );

endmodule

`default_nettype wire

//--- verification/memSubsystem_asserts.sv
// occupancy is rebuilt from push and pop strobes, FIFO_DEPTH must equal the FIFO's DEPTH
`timescale 1ns/1ps
`default_nettype none

module memSubsystemAsserts #(
    parameter int FIFO_DEPTH = 4
) (
    input logic clk,
    input logic reset,
    input logic inReady,
    input logic pushValid,
    input logic popTake,
    input logic rspValid
);

    int fifoLevel;

    // mirrors the FIFO count, pops only happen when not empty
    always_ff @(posedge clk) begin
        if (reset) begin
            fifoLevel <= 0;
        end else begin
            fifoLevel <= fifoLevel + int'(pushValid) - int'(popTake);
        end
    end

    noReadyWhenFull: assert property (@(posedge clk) disable iff (reset)
        (fifoLevel == FIFO_DEPTH) |-> !inReady)
        else $error("inReady high while the FIFO is full");

    // a response only follows a take in the previous cycle
    noResponseWithoutTake: assert property (@(posedge clk) disable iff (reset)
        !popTake |=> !rspValid)
        else $error("rspValid high without a take one cycle earlier");

    quietAfterReset: assert property (@(posedge clk)
        reset |=> (!rspValid && !popTake))
        else $error("rspValid or popTake high right after reset");

endmodule

bind memSubsystem memSubsystemAsserts #(
    .FIFO_DEPTH(FIFO_DEPTH)
) asserts (
    .clk       (clk),
    .reset     (reset),
    .inReady   (inReady),
    .pushValid (pushValid),
    .popTake   (popTake),
    .rspValid  (rspValid)
);

`default_nettype wire

//--- verification/memSubsystemTb.sv
// model covers 16 words (ADDR_WIDTH 4), read latency is only checked while rspStall stays low
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
    import memPkg::*;

    localparam int ADDR_WIDTH     = 4;
    localparam int FIFO_DEPTH     = 4;
    localparam int WORDS          = 1 << ADDR_WIDTH;
    localparam int RANDOM_COUNT   = 300;
    localparam int BURST_CYCLES   = 12;
    localparam int LATENCY_COUNT  = 60;
    localparam int DRAIN_CYCLES   = 16;
    localparam int TOTAL_REQUESTS = 2 * WORDS + RANDOM_COUNT + BURST_CYCLES + LATENCY_COUNT;
    localparam int CYCLE_LIMIT    = 20 * TOTAL_REQUESTS + 200;

    // one outstanding read as the model expects it
    typedef struct packed {
        dataT     data;
        byteMaskT err;
        int       cycle;
        logic     strict;
    } expectT;

    logic        clk;
    logic        reset;
    logic        inValid;
    logic        inReady;
    memRequestT  inReq;
    logic        rspStall;
    logic        rspValid;
    memResponseT rsp;

    dataT        modelData [WORDS];
    byteMaskT    modelPoison [WORDS];
    expectT      expected [$];
    logic [31:0] randState;
    int          cycleCount;
    int          errorCount;
    int          checkCount;
    int          stallMode;
    logic        strictLatency;

    memSubsystem #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .inReady  (inReady),
        .inReq    (inReq),
        .rspStall (rspStall),
        .rspValid (rspValid),
        .rsp      (rsp)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = randState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        randState = x;
        return x;
    endfunction

    // poison on about one write in eight, reads never carry it
    function automatic memRequestT randomRequest(input logic write);
        memRequestT  req;
        logic [31:0] r;
        r            = nextRandom();
        req.write    = write;
        req.poison   = write && ((r & 32'h7) == 32'h0);
        req.byteMask = byteMaskT'(r >> 3);
        req.addr     = addrT'(r >> 7);
        req.data     = nextRandom();
        return req;
    endfunction

    task automatic compareData(input string name, input dataT got, input dataT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareErr(input string name, input byteMaskT got, input byteMaskT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reportAndFinish();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // requests run in order, so the model is updated at acceptance
    task automatic trackRequest(input memRequestT req, input int cycle);
        logic [ADDR_WIDTH-1:0] index;
        expectT                entry;
        index = req.addr[ADDR_WIDTH-1:0];
        if (req.write) begin
            for (int b = 0; b < BYTE_COUNT; b++) begin
                if (req.byteMask[b]) begin
                    modelData[index][b*8 +: 8] = req.data[b*8 +: 8];
                    modelPoison[index][b]      = req.poison;
                end
            end
        end else begin
            entry.data   = modelData[index];
            entry.err    = modelPoison[index];
            entry.cycle  = cycle;
            entry.strict = strictLatency;
            expected.push_back(entry);
        end
    endtask

    task automatic checkResponse();
        expectT entry;
        if (expected.size() == 0) begin
            errorCount++;
            $display("response arrived with no read outstanding");
        end else begin
            entry = expected.pop_front();
            compareData("rsp.data", rsp.data, entry.data);
            compareErr("rsp.parityErr", rsp.parityErr, entry.err);
            if (entry.strict && (cycleCount - entry.cycle != 3)) begin
                errorCount++;
                $display("read answered %0d cycles after acceptance instead of 3",
                         cycleCount - entry.cycle);
            end
        end
    endtask

    // monitor samples at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (reset) begin
            cycleCount = 0;
        end else begin
            cycleCount = cycleCount + 1;
            if (inValid && inReady) begin
                trackRequest(inReq, cycleCount);
            end
            if (rspValid) begin
                checkResponse();
            end
            if (cycleCount >= CYCLE_LIMIT) begin
                errorCount++;
                $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
                reportAndFinish();
            end
        end
    end

    // stall mode 0 keeps rspStall low, 1 randomizes it, 2 holds it high
    task automatic tick();
        @(posedge clk);
        case (stallMode)
            1:       rspStall <= ((nextRandom() & 32'h3) == 32'h0);
            2:       rspStall <= 1'b1;
            default: rspStall <= 1'b0;
        endcase
    endtask

    task automatic sendRequest(input memRequestT req);
        inValid <= 1'b1;
        inReq   <= req;
        do begin
            tick();
        end while (!inReady);
    endtask

    task automatic drain();
        inValid   <= 1'b0;
        stallMode = 0;
        repeat (DRAIN_CYCLES) tick();
    endtask

    initial begin
        memRequestT req;
        int         accepted;
        reset         = 1'b1;
        inValid       = 1'b0;
        inReq         = '0;
        rspStall      = 1'b0;
        randState     = 32'd88;
        errorCount    = 0;
        checkCount    = 0;
        stallMode     = 0;
        strictLatency = 1'b1;
        repeat (4) tick();
        reset <= 1'b0;
        tick();
        if (!inReady) begin
            errorCount++;
            $display("inReady is low after reset");
        end

        // fill every word with clean data, then read it all back
        for (int a = 0; a < 2 * WORDS; a++) begin
            req          = randomRequest(a < WORDS);
            req.poison   = 1'b0;
            req.byteMask = 4'hF;
            req.addr     = addrT'(a % WORDS);
            sendRequest(req);
        end
        drain();

        // masked and poisoned traffic with random back-pressure
        strictLatency <= 1'b0;
        stallMode = 1;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            if ((nextRandom() & 32'h3) == 32'h0) begin
                inValid <= 1'b0;
                tick();
            end
            sendRequest(randomRequest((nextRandom() & 32'h1) != 32'h0));
        end
        drain();

        // hold the stall and offer a request every cycle
        stallMode = 2;
        tick();
        accepted = 0;
        inValid <= 1'b1;
        inReq   <= randomRequest((nextRandom() & 32'h3) == 32'h0);
        for (int i = 0; i < BURST_CYCLES; i++) begin
            tick();
            if (inReady) begin
                accepted++;
                inReq <= randomRequest((nextRandom() & 32'h3) == 32'h0);
            end
        end
        if (accepted != FIFO_DEPTH || inReady) begin
            errorCount++;
            $display("stalled burst took %0d requests, inReady %0d, FIFO holds %0d",
                     accepted, inReady, FIFO_DEPTH);
        end
        drain();

        // no stall here, every read must answer in exactly 3 cycles
        strictLatency <= 1'b1;
        for (int i = 0; i < LATENCY_COUNT; i++) begin
            if ((nextRandom() & 32'h7) == 32'h0) begin
                inValid <= 1'b0;
                tick();
            end
            sendRequest(randomRequest((nextRandom() & 32'h3) == 32'h0));
        end
        drain();

        if (expected.size() != 0) begin
            errorCount++;
            $display("%0d reads never got a response", expected.size());
        end
        reportAndFinish();
    end

endmodule

`default_nettype wire

//--- memSubsystem.f
src/memPkg.sv
src/requestIssuer.sv
src/creditFifo.sv
src/parityMemory.sv
src/memSubsystem.sv
verification/memSubsystem_asserts.sv
verification/memSubsystemTb.sv

//--- Makefile
SIM = obj_dir/VmemSubsystemTb
SOURCES = $(wildcard src/*.sv) $(wildcard verification/*.sv)

all: run

$(SIM): memSubsystem.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module memSubsystemTb -f memSubsystem.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
